//--- hw/ycc2rgb_pkg.sv
////////////////////////////////////////////////////////////////////////////
// ycc2rgb shared definitions
// pixel and arithmetic widths, default BT.601 coefficients in 1/256 units
// and the sum word that the adders and the clamp read in two ways
////////////////////////////////////////////////////////////////////////////

package ycc2rgb_pkg;

	// pixel component width
	localparam int PIX_W	= 8;
	// signed width of table terms and sums
	// sign + over bit + pixel field, wide enough that no sum wraps
	localparam int CALC_W	= 10;
	// coefficient width, 1/256 units
	localparam int COEF_W	= 10;

	// default coefficients, BT.601 full range
	// R = Y + 1.402 V'
	localparam logic [COEF_W-1:0] COEF_RV_DEF	= 10'd359;
	// G = Y - 0.344 U' - 0.714 V'
	localparam logic [COEF_W-1:0] COEF_GU_DEF	= 10'd88;
	localparam logic [COEF_W-1:0] COEF_GV_DEF	= 10'd183;
	// B = Y + 1.772 U'
	localparam logic [COEF_W-1:0] COEF_BU_DEF	= 10'd454;

	////////////////////////////////////////////////////////////////////////
	// sum word
	// num : two's complement value for the adder stages
	// fld : sign, over and pixel field for the output clamp
	//       over is set for values of 256 and up when sgn is clear
	////////////////////////////////////////////////////////////////////////
	typedef union packed
	{
		logic signed [CALC_W-1:0]	num;
		struct packed
		{
			logic				sgn;
			logic				over;
			logic [PIX_W-1:0]	pix;
		} fld;
	} calc_word_t;

endpackage

//--- hw/coef_lut.sv
////////////////////////////////////////////////////////////////////////////
// coefficient lookup table
// 256-entry ROM of one coefficient times a centred chroma value,
// registered read with one cycle of latency
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module coef_lut
#(
	parameter logic [ycc2rgb_pkg::COEF_W-1:0] P_COEF = ycc2rgb_pkg::COEF_RV_DEF
)
(
	input	logic								i_pclk,
	input	logic [ycc2rgb_pkg::PIX_W-1:0]		i_addr,
	output	logic signed [ycc2rgb_pkg::CALC_W-1:0]	o_term
);

	localparam int DEPTH	= 1 << ycc2rgb_pkg::PIX_W;
	// chroma zero point
	localparam int MID		= 1 << (ycc2rgb_pkg::PIX_W - 1);

	logic signed [ycc2rgb_pkg::CALC_W-1:0] rom [DEPTH];

	// (coef * (x - 128) + 128) >>> 8
	// half an lsb added before the shift, rounds to nearest
	function automatic logic signed [ycc2rgb_pkg::CALC_W-1:0] term_of(input int x);
		int coef;
		int prod;
		int shifted;
		coef	= int'(P_COEF);
		prod	= coef * (x - MID) + 128;
		shifted	= prod >>> 8;
		return shifted[ycc2rgb_pkg::CALC_W-1:0];
	endfunction

	// table contents fixed at elaboration
	initial
	begin
		for (int i = 0; i < DEPTH; i++)
			rom[i] = term_of(i);
	end

	// block-ROM style read, output register only
	always_ff @(posedge i_pclk)
	begin
		o_term <= rom[i_addr];
	end

endmodule

//--- hw/ycc2rgb_matrix.sv
////////////////////////////////////////////////////////////////////////////
// ycc2rgb conversion matrix
// input register, four coefficient tables and two adder stages;
// produces unclamped R, G and B sums four cycles after the input
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ycc2rgb_matrix
#(
	parameter logic [ycc2rgb_pkg::COEF_W-1:0] P_COEF_RV = ycc2rgb_pkg::COEF_RV_DEF,
	parameter logic [ycc2rgb_pkg::COEF_W-1:0] P_COEF_GU = ycc2rgb_pkg::COEF_GU_DEF,
	parameter logic [ycc2rgb_pkg::COEF_W-1:0] P_COEF_GV = ycc2rgb_pkg::COEF_GV_DEF,
	parameter logic [ycc2rgb_pkg::COEF_W-1:0] P_COEF_BU = ycc2rgb_pkg::COEF_BU_DEF
)
(
	input	logic							i_arst,
	input	logic							i_pclk,
	input	logic							i_de,
	input	logic [ycc2rgb_pkg::PIX_W-1:0]	i_y,
	input	logic [ycc2rgb_pkg::PIX_W-1:0]	i_u,
	input	logic [ycc2rgb_pkg::PIX_W-1:0]	i_v,
	output	logic							o_de,
	output	ycc2rgb_pkg::calc_word_t		o_r_sum,
	output	ycc2rgb_pkg::calc_word_t		o_g_sum,
	output	ycc2rgb_pkg::calc_word_t		o_b_sum
);

	// stage 1, registered input
	logic							r_de_1p;
	logic [ycc2rgb_pkg::PIX_W-1:0]	r_y_1p;
	logic [ycc2rgb_pkg::PIX_W-1:0]	r_u_1p;
	logic [ycc2rgb_pkg::PIX_W-1:0]	r_v_1p;

	// stage 2, table terms and aligned Y
	logic							r_de_2p;
	logic [ycc2rgb_pkg::PIX_W-1:0]	r_y_2p;
	logic signed [ycc2rgb_pkg::CALC_W-1:0]	w_t_rv_2p;
	logic signed [ycc2rgb_pkg::CALC_W-1:0]	w_t_gu_2p;
	logic signed [ycc2rgb_pkg::CALC_W-1:0]	w_t_gv_2p;
	logic signed [ycc2rgb_pkg::CALC_W-1:0]	w_t_bu_2p;
	// Y zero-extended into the sum width
	logic signed [ycc2rgb_pkg::CALC_W-1:0]	w_y_ext_2p;

	// stage 3, partial sums
	logic							r_de_3p;
	ycc2rgb_pkg::calc_word_t		r_r_3p;
	ycc2rgb_pkg::calc_word_t		r_g_3p;
	ycc2rgb_pkg::calc_word_t		r_b_3p;
	logic signed [ycc2rgb_pkg::CALC_W-1:0]	r_t_gv_3p;

	// stage 4, final sums
	logic							r_de_4p;
	ycc2rgb_pkg::calc_word_t		r_r_4p;
	ycc2rgb_pkg::calc_word_t		r_g_4p;
	ycc2rgb_pkg::calc_word_t		r_b_4p;

	//////////////////////////////////////////////////////////////////////////
	// chroma tables, addressed from stage 1, terms valid at stage 2
	//////////////////////////////////////////////////////////////////////////
	coef_lut #(.P_COEF(P_COEF_RV)) u_lut_rv
	(
		.i_pclk	(i_pclk),
		.i_addr	(r_v_1p),
		.o_term	(w_t_rv_2p)
	);

	coef_lut #(.P_COEF(P_COEF_GU)) u_lut_gu
	(
		.i_pclk	(i_pclk),
		.i_addr	(r_u_1p),
		.o_term	(w_t_gu_2p)
	);

	coef_lut #(.P_COEF(P_COEF_GV)) u_lut_gv
	(
		.i_pclk	(i_pclk),
		.i_addr	(r_v_1p),
		.o_term	(w_t_gv_2p)
	);

	coef_lut #(.P_COEF(P_COEF_BU)) u_lut_bu
	(
		.i_pclk	(i_pclk),
		.i_addr	(r_u_1p),
		.o_term	(w_t_bu_2p)
	);

	assign w_y_ext_2p = {{(ycc2rgb_pkg::CALC_W - ycc2rgb_pkg::PIX_W){1'b0}}, r_y_2p};

	always_ff @(posedge i_pclk or posedge i_arst)
	begin
		if (i_arst)
		begin
			r_de_1p		<= 1'b0;
			r_y_1p		<= '0;
			r_u_1p		<= '0;
			r_v_1p		<= '0;
			r_de_2p		<= 1'b0;
			r_y_2p		<= '0;
			r_de_3p		<= 1'b0;
			r_r_3p		<= '0;
			r_g_3p		<= '0;
			r_b_3p		<= '0;
			r_t_gv_3p	<= '0;
			r_de_4p		<= 1'b0;
			r_r_4p		<= '0;
			r_g_4p		<= '0;
			r_b_4p		<= '0;
		end
		else
		begin
			// input
			r_de_1p		<= i_de;
			r_y_1p		<= i_y;
			r_u_1p		<= i_u;
			r_v_1p		<= i_v;
			// match the table read
			r_de_2p		<= r_de_1p;
			r_y_2p		<= r_y_1p;
			// first adder stage
			r_de_3p		<= r_de_2p;
			r_r_3p.num	<= w_y_ext_2p + w_t_rv_2p;
			r_g_3p.num	<= w_y_ext_2p - w_t_gu_2p;
			r_b_3p.num	<= w_y_ext_2p + w_t_bu_2p;
			// green V term waits one stage
			r_t_gv_3p	<= w_t_gv_2p;
			// second adder stage, only green has a third operand
			r_de_4p		<= r_de_3p;
			r_r_4p		<= r_r_3p;
			r_g_4p.num	<= r_g_3p.num - r_t_gv_3p;
			r_b_4p		<= r_b_3p;
		end
	end

	assign o_de		= r_de_4p;
	assign o_r_sum	= r_r_4p;
	assign o_g_sum	= r_g_4p;
	assign o_b_sum	= r_b_4p;

endmodule

//--- hw/pixel_delay.sv
////////////////////////////////////////////////////////////////////////////
// bypass pixel delay
// four-deep shift register of the raw YCbCr pixel, lines the bypass
// path up with the matrix sums
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pixel_delay
(
	input	logic							i_arst,
	input	logic							i_pclk,
	input	logic [ycc2rgb_pkg::PIX_W-1:0]	i_y,
	input	logic [ycc2rgb_pkg::PIX_W-1:0]	i_u,
	input	logic [ycc2rgb_pkg::PIX_W-1:0]	i_v,
	output	logic [ycc2rgb_pkg::PIX_W-1:0]	o_y,
	output	logic [ycc2rgb_pkg::PIX_W-1:0]	o_u,
	output	logic [ycc2rgb_pkg::PIX_W-1:0]	o_v
);

	// same depth as input reg to final sums
	localparam int DEPTH	= 4;
	localparam int WORD_W	= 3 * ycc2rgb_pkg::PIX_W;

	logic [WORD_W-1:0] r_pix [DEPTH];

	// always shifts, no enable
	always_ff @(posedge i_pclk or posedge i_arst)
	begin
		if (i_arst)
		begin
			for (int i = 0; i < DEPTH; i++)
				r_pix[i] <= '0;
		end
		else
		begin
			r_pix[0] <= {i_v, i_u, i_y};
			for (int i = 1; i < DEPTH; i++)
				r_pix[i] <= r_pix[i-1];
		end
	end

	assign {o_v, o_u, o_y} = r_pix[DEPTH-1];

endmodule

//--- hw/ycc2rgb_clamp.sv
////////////////////////////////////////////////////////////////////////////
// ycc2rgb output stage
// clamps the matrix sums to 0..255 or, with the converter disabled,
// registers the delayed input pixel unchanged
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ycc2rgb_clamp
(
	input	logic							i_arst,
	input	logic							i_pclk,
	input	logic							i_en,
	input	logic							i_de,
	input	ycc2rgb_pkg::calc_word_t		i_r_sum,
	input	ycc2rgb_pkg::calc_word_t		i_g_sum,
	input	ycc2rgb_pkg::calc_word_t		i_b_sum,
	input	logic [ycc2rgb_pkg::PIX_W-1:0]	i_byp_y,
	input	logic [ycc2rgb_pkg::PIX_W-1:0]	i_byp_u,
	input	logic [ycc2rgb_pkg::PIX_W-1:0]	i_byp_v,
	output	logic							o_de,
	output	logic [ycc2rgb_pkg::PIX_W-1:0]	o_r,
	output	logic [ycc2rgb_pkg::PIX_W-1:0]	o_g,
	output	logic [ycc2rgb_pkg::PIX_W-1:0]	o_b
);

	// saturate one sum
	// negative -> 0, 256 and up -> 255, else the low byte
	function automatic logic [ycc2rgb_pkg::PIX_W-1:0] clamp_pix
	(
		input ycc2rgb_pkg::calc_word_t w
	);
		if (w.fld.sgn)
			return '0;
		else if (w.fld.over)
			return '1;
		else
			return w.fld.pix;
	endfunction

	always_ff @(posedge i_pclk or posedge i_arst)
	begin
		if (i_arst)
		begin
			o_de	<= 1'b0;
			o_r		<= '0;
			o_g		<= '0;
			o_b		<= '0;
		end
		else
		begin
			o_de	<= i_de;
			if (i_en)
			begin
				o_r	<= clamp_pix(i_r_sum);
				o_g	<= clamp_pix(i_g_sum);
				o_b	<= clamp_pix(i_b_sum);
			end
			else
			begin
				// passthrough, Y on R, Cb on G, Cr on B
				o_r	<= i_byp_y;
				o_g	<= i_byp_u;
				o_b	<= i_byp_v;
			end
		end
	end

endmodule

//--- hw/ycc2rgb_top.sv
////////////////////////////////////////////////////////////////////////////
// YCbCr to RGB converter, top level
// five-cycle pipeline from an 8-bit YCbCr pixel to 8-bit RGB,
// with a same-latency bypass when disabled
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ycc2rgb_top
#(
	// BT.709 works as well: 403, 48, 120, 475
	parameter logic [ycc2rgb_pkg::COEF_W-1:0] P_COEF_RV = ycc2rgb_pkg::COEF_RV_DEF,
	parameter logic [ycc2rgb_pkg::COEF_W-1:0] P_COEF_GU = ycc2rgb_pkg::COEF_GU_DEF,
	parameter logic [ycc2rgb_pkg::COEF_W-1:0] P_COEF_GV = ycc2rgb_pkg::COEF_GV_DEF,
	parameter logic [ycc2rgb_pkg::COEF_W-1:0] P_COEF_BU = ycc2rgb_pkg::COEF_BU_DEF
)
(
	input	logic							i_arst,
	input	logic							i_pclk,
	// converter on, low selects bypass
	input	logic							i_en,
	input	logic							i_de,
	input	logic [ycc2rgb_pkg::PIX_W-1:0]	i_y,
	input	logic [ycc2rgb_pkg::PIX_W-1:0]	i_u,
	input	logic [ycc2rgb_pkg::PIX_W-1:0]	i_v,
	output	logic							o_de,
	output	logic [ycc2rgb_pkg::PIX_W-1:0]	o_r,
	output	logic [ycc2rgb_pkg::PIX_W-1:0]	o_g,
	output	logic [ycc2rgb_pkg::PIX_W-1:0]	o_b
);

	// matrix to clamp, stage 4
	logic							w_de_4p;
	ycc2rgb_pkg::calc_word_t		w_r_sum_4p;
	ycc2rgb_pkg::calc_word_t		w_g_sum_4p;
	ycc2rgb_pkg::calc_word_t		w_b_sum_4p;

	// raw pixel, same stage
	logic [ycc2rgb_pkg::PIX_W-1:0]	w_byp_y_4p;
	logic [ycc2rgb_pkg::PIX_W-1:0]	w_byp_u_4p;
	logic [ycc2rgb_pkg::PIX_W-1:0]	w_byp_v_4p;

	ycc2rgb_matrix
	#(
		.P_COEF_RV	(P_COEF_RV),
		.P_COEF_GU	(P_COEF_GU),
		.P_COEF_GV	(P_COEF_GV),
		.P_COEF_BU	(P_COEF_BU)
	)
	u_matrix
	(
		.i_arst		(i_arst),
		.i_pclk		(i_pclk),
		.i_de		(i_de),
		.i_y		(i_y),
		.i_u		(i_u),
		.i_v		(i_v),
		.o_de		(w_de_4p),
		.o_r_sum	(w_r_sum_4p),
		.o_g_sum	(w_g_sum_4p),
		.o_b_sum	(w_b_sum_4p)
	);

	pixel_delay u_pixel_delay
	(
		.i_arst	(i_arst),
		.i_pclk	(i_pclk),
		.i_y	(i_y),
		.i_u	(i_u),
		.i_v	(i_v),
		.o_y	(w_byp_y_4p),
		.o_u	(w_byp_u_4p),
		.o_v	(w_byp_v_4p)
	);

	// fifth register, mode picked here
	ycc2rgb_clamp u_clamp
	(
		.i_arst		(i_arst),
		.i_pclk		(i_pclk),
		.i_en		(i_en),
		.i_de		(w_de_4p),
		.i_r_sum	(w_r_sum_4p),
		.i_g_sum	(w_g_sum_4p),
		.i_b_sum	(w_b_sum_4p),
		.i_byp_y	(w_byp_y_4p),
		.i_byp_u	(w_byp_u_4p),
		.i_byp_v	(w_byp_v_4p),
		.o_de		(o_de),
		.o_r		(o_r),
		.o_g		(o_g),
		.o_b		(o_b)
	);

endmodule

//--- sim/tb_ycc2rgb_model.svh
////////////////////////////////////////////////////////////////////////////
// ycc2rgb reference model
// expected RGB per pixel from the lookup-term rule, the xorshift
// stimulus source and the queue of pixels still in flight
////////////////////////////////////////////////////////////////////////////

// one pixel as the DUT samples it, raw and converted
typedef struct packed
{
	logic							rst;
	logic							de;
	logic							en;
	logic [ycc2rgb_pkg::PIX_W-1:0]	y;
	logic [ycc2rgb_pkg::PIX_W-1:0]	u;
	logic [ycc2rgb_pkg::PIX_W-1:0]	v;
	logic [ycc2rgb_pkg::PIX_W-1:0]	r;
	logic [ycc2rgb_pkg::PIX_W-1:0]	g;
	logic [ycc2rgb_pkg::PIX_W-1:0]	b;
} exp_rec_t;

// inputs of the last PIPE_LAT edges, oldest first
exp_rec_t hist[$];

logic [31:0] rng_state = 32'd76;

// xorshift32, shifts 13 / 17 / 5
function automatic logic [31:0] next_rand();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

function automatic logic [ycc2rgb_pkg::PIX_W-1:0] rand_byte();
	logic [31:0] r;
	r = next_rand();
	return r[ycc2rgb_pkg::PIX_W-1:0];
endfunction

function automatic logic rand_bit();
	logic [31:0] r;
	r = next_rand();
	return r[9];
endfunction

// coef * (x - 128) in 1/256 units, rounded, floor on the shift
function automatic int lut_term(input int coef, input int x);
	return (coef * (x - 128) + 128) >>> 8;
endfunction

function automatic logic [ycc2rgb_pkg::PIX_W-1:0] clamp_byte(input int s);
	if (s < 0)
		return '0;
	else if (s > 255)
		return '1;
	else
		return s[ycc2rgb_pkg::PIX_W-1:0];
endfunction

function automatic exp_rec_t model_pixel
(
	input logic							rst,
	input logic							de,
	input logic							en,
	input logic [ycc2rgb_pkg::PIX_W-1:0]	y,
	input logic [ycc2rgb_pkg::PIX_W-1:0]	u,
	input logic [ycc2rgb_pkg::PIX_W-1:0]	v
);
	exp_rec_t rec;
	int yi;
	int ui;
	int vi;
	yi		= int'(y);
	ui		= int'(u);
	vi		= int'(v);
	rec.rst	= rst;
	rec.de	= de;
	rec.en	= en;
	rec.y	= y;
	rec.u	= u;
	rec.v	= v;
	// default BT.601 terms
	rec.r	= clamp_byte(yi + lut_term(int'(ycc2rgb_pkg::COEF_RV_DEF), vi));
	rec.g	= clamp_byte(yi - lut_term(int'(ycc2rgb_pkg::COEF_GU_DEF), ui)
		- lut_term(int'(ycc2rgb_pkg::COEF_GV_DEF), vi));
	rec.b	= clamp_byte(yi + lut_term(int'(ycc2rgb_pkg::COEF_BU_DEF), ui));
	return rec;
endfunction

//--- sim/tb_ycc2rgb.sv
////////////////////////////////////////////////////////////////////////////
// ycc2rgb testbench
// reset, conversion, clamp corners, bypass and de gaps with mode changes,
// every output cycle checked against the reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ycc2rgb;

	localparam int PIPE_LAT		= 5;
	localparam int PIX_W		= ycc2rgb_pkg::PIX_W;
	localparam int RST_CYCLES	= 8;
	localparam int DRAIN_LIMIT	= 8 * PIPE_LAT;

	logic				i_arst;
	logic				i_pclk = 1'b0;
	logic				i_en;
	logic				i_de;
	logic [PIX_W-1:0]	i_y;
	logic [PIX_W-1:0]	i_u;
	logic [PIX_W-1:0]	i_v;
	logic				o_de;
	logic [PIX_W-1:0]	o_r;
	logic [PIX_W-1:0]	o_g;
	logic [PIX_W-1:0]	o_b;

	int		err_cnt		= 0;
	int		chk_cnt		= 0;
	int		sent_cnt	= 0;
	int		out_cnt		= 0;
	int		test_cnt	= 0;
	int		err_mark	= 0;
	int		chk_mark	= 0;
	logic	timed_out	= 1'b0;

	`include "tb_ycc2rgb_model.svh"

	ycc2rgb_top u_dut
	(
		.i_arst	(i_arst),
		.i_pclk	(i_pclk),
		.i_en	(i_en),
		.i_de	(i_de),
		.i_y	(i_y),
		.i_u	(i_u),
		.i_v	(i_v),
		.o_de	(o_de),
		.o_r	(o_r),
		.o_g	(o_g),
		.o_b	(o_b)
	);

	// 8 ns pixel clock
	initial
	begin
		forever
			#4 i_pclk = ~i_pclk;
	end

	////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////
	task automatic send_pixel(input logic de, input logic en, input logic [PIX_W-1:0] y,
		input logic [PIX_W-1:0] u, input logic [PIX_W-1:0] v);
		@(posedge i_pclk);
		i_de	<= de;
		i_en	<= en;
		i_y		<= y;
		i_u		<= u;
		i_v		<= v;
	endtask

	task automatic report_bad_value(input string name, input logic [PIX_W-1:0] got,
		input logic [PIX_W-1:0] want);
		err_cnt++;
		$display("mismatch at %0t: %s is %0d, model expects %0d", $time, name, got, want);
	endtask

	// idle the input and wait for every sent pixel to come out
	task automatic drain_pipeline(input string name);
		int waited;
		waited = 0;
		@(posedge i_pclk);
		i_de <= 1'b0;
		while (out_cnt < sent_cnt && waited < DRAIN_LIMIT)
		begin
			@(posedge i_pclk);
			waited++;
		end
		if (out_cnt < sent_cnt)
		begin
			$display("timeout in test %s: only %0d of %0d pixels came out after %0d cycles",
				name, out_cnt, sent_cnt, waited);
			timed_out = 1'b1;
		end
	endtask

	task automatic begin_test();
		err_mark = err_cnt;
		chk_mark = chk_cnt;
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		if (timed_out)
			$display("test %s: timed out", name);
		else
			$display("test %s: %0d checks, %0d errors", name, chk_cnt - chk_mark,
				err_cnt - err_mark);
	endtask

	////////////////////////////////////////////////////////////////////////
	// output checker
	// outputs are stable at the falling edge; hist[0] is the pixel due now,
	// the newest entry holds the mode the output register just sampled
	////////////////////////////////////////////////////////////////////////
	always @(negedge i_pclk)
	begin : check_outputs
		exp_rec_t			px;
		logic				want_de;
		logic [PIX_W-1:0]	want_r;
		logic [PIX_W-1:0]	want_g;
		logic [PIX_W-1:0]	want_b;
		px = hist[0];
		if (px.rst)
		begin
			// reset state as read with bypass selected
			want_de	= 1'b0;
			want_r	= '0;
			want_g	= '0;
			want_b	= '0;
		end
		else if (hist[PIPE_LAT-1].en)
		begin
			want_de	= px.de;
			want_r	= px.r;
			want_g	= px.g;
			want_b	= px.b;
		end
		else
		begin
			// bypass puts Y U V on R G B
			want_de	= px.de;
			want_r	= px.y;
			want_g	= px.u;
			want_b	= px.v;
		end
		assert (o_de === want_de)
			else report_bad_value("o_de", PIX_W'(o_de), PIX_W'(want_de));
		assert (o_r === want_r)
			else report_bad_value("o_r", o_r, want_r);
		assert (o_g === want_g)
			else report_bad_value("o_g", o_g, want_g);
		assert (o_b === want_b)
			else report_bad_value("o_b", o_b, want_b);
		chk_cnt = chk_cnt + 4;
		if (o_de === 1'b1)
			out_cnt++;
		// the pixel the DUT samples at the next edge
		if (i_de && !i_arst)
			sent_cnt++;
		void'(hist.pop_front());
		hist.push_back(model_pixel(i_arst, i_de, i_en, i_y, i_u, i_v));
	end

	////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////
	task automatic reset_test();
		begin_test();
		// inputs under reset never reach the outputs
		for (int i = 0; i < RST_CYCLES - 1; i++)
			send_pixel(1'b1, 1'b0, rand_byte(), rand_byte(), rand_byte());
		// release on the eighth edge
		@(posedge i_pclk);
		i_arst	<= 1'b0;
		i_de	<= 1'b0;
		// reset state drains out over the latency while bypass keeps it at zero
		for (int i = 0; i < 2 * PIPE_LAT; i++)
			send_pixel(1'b0, 1'b0, rand_byte(), rand_byte(), rand_byte());
		drain_pipeline("reset");
		end_test("reset");
	endtask

	task automatic conversion_test();
		begin_test();
		for (int i = 0; i < 300; i++)
			send_pixel(1'b1, 1'b1, rand_byte(), rand_byte(), rand_byte());
		drain_pipeline("conversion");
		end_test("conversion");
	endtask

	// every 0 / 255 combination saturates some channel both ways
	task automatic clamp_test();
		begin_test();
		for (int k = 0; k < 8; k++)
			send_pixel(1'b1, 1'b1, {PIX_W{k[2]}}, {PIX_W{k[1]}}, {PIX_W{k[0]}});
		drain_pipeline("clamp");
		end_test("clamp");
	endtask

	task automatic bypass_test();
		begin_test();
		for (int i = 0; i < 100; i++)
			send_pixel(1'b1, 1'b0, rand_byte(), rand_byte(), rand_byte());
		drain_pipeline("bypass");
		end_test("bypass");
	endtask

	// random de pattern with mode flips while pixels are in flight
	task automatic gap_test();
		logic	en;
		int		len;
		begin_test();
		for (int n = 0; n < 24; n++)
		begin
			en	= rand_bit();
			len	= int'(rand_byte() & 8'h0f) + 1;
			for (int j = 0; j < len; j++)
				send_pixel(rand_bit(), en, rand_byte(), rand_byte(), rand_byte());
		end
		drain_pipeline("gaps");
		end_test("gaps");
	endtask

	initial
	begin
		i_arst	= 1'b1;
		i_en	= 1'b0;
		i_de	= 1'b0;
		i_y		= '0;
		i_u		= '0;
		i_v		= '0;
		// pipeline starts in reset state
		for (int i = 0; i < PIPE_LAT; i++)
			hist.push_back(model_pixel(1'b1, 1'b0, 1'b0, '0, '0, '0));
		reset_test();
		if (!timed_out)
			conversion_test();
		if (!timed_out)
			clamp_test();
		if (!timed_out)
			bypass_test();
		if (!timed_out)
			gap_test();
		$display("%0d tests run, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
		if (timed_out || err_cnt != 0)
			$display("sim failed");
		else
			$display("sim passed");
		$finish;
	end

endmodule

//--- ycc2rgb_top.f
+incdir+sim
hw/ycc2rgb_pkg.sv
hw/coef_lut.sv
hw/ycc2rgb_matrix.sv
hw/pixel_delay.sv
hw/ycc2rgb_clamp.sv
hw/ycc2rgb_top.sv
sim/tb_ycc2rgb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the ycc2rgb testbench with Verilator
# the run passes only if the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG" \
	&& verilator --binary --timing --assert -j 0 \
		--top-module tb_ycc2rgb \
		-f ycc2rgb_top.f \
		-o tb_ycc2rgb \
	&& ./obj_dir/tb_ycc2rgb > "$LOG" 2>&1 \
	|| { echo "build or simulation error"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"

grep -qx "sim passed" "$LOG" \
	&& { echo "result: PASS"; exit 0; } \
	|| { echo "result: FAIL"; exit 1; }
